//--- hdl/oq_pkg.sv
package oq_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // queue geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int NUM_QUEUES  = 5;
   localparam int QUEUE_IDX_W = 3;
   localparam int PAYLOAD_W   = 16;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // axi-lite responses and register offsets
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam logic [1:0] AXI_RESP_OK     = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

   localparam logic [7:0] REG_QUEUES_NUM        = 8'h00;
   localparam logic [7:0] REG_RESET_DROP_COUNTS = 8'h01;
   // drop count n sits at base + n
   localparam logic [7:0] REG_DROP_COUNT_BASE   = 8'h10;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // descriptors
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // incoming packet descriptor
   typedef struct packed {
      logic [QUEUE_IDX_W-1:0] dst_queue;
      logic [PAYLOAD_W-1:0]   payload;
   } oq_pkt_t;

   // decode to queue bank
   typedef struct packed {
      logic                   valid;
      logic                   drop;
      logic [QUEUE_IDX_W-1:0] queue;
      logic [PAYLOAD_W-1:0]   payload;
   } oq_enq_t;

endpackage

//--- hdl/oq_port_decode.sv
`timescale 1ns/1ps

module oq_port_decode
   import oq_pkg::*;
(
   input  logic        ARESETN,
   input  logic        ACLK,
   input  logic        pkt_valid,
   input  oq_pkt_t     pkt,
   input  logic [31:0] queues_num,
   output oq_enq_t     enq
);

   logic                   in_range;
   logic                   enabled;

   logic                   enq_valid;
   logic                   enq_drop;
   logic [QUEUE_IDX_W-1:0] enq_queue;
   logic [PAYLOAD_W-1:0]   enq_payload;

   // physical queue exists at all
   assign in_range = (pkt.dst_queue < QUEUE_IDX_W'(NUM_QUEUES));

   // queue enabled by software
   assign enabled  = (32'(pkt.dst_queue) < queues_num);

   // out of range strobes vanish here and are never counted
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         enq_valid <= 1'b0;
      end
      else begin
         enq_valid <= pkt_valid && in_range;
      end
   end

   always_ff @(posedge ACLK) begin
      enq_drop    <= !enabled;
      enq_queue   <= pkt.dst_queue;
      enq_payload <= pkt.payload;
   end

   assign enq = '{
      valid:   enq_valid,
      drop:    enq_drop,
      queue:   enq_queue,
      payload: enq_payload
   };

endmodule

//--- hdl/oq_queue_bank.sv
`timescale 1ns/1ps

module oq_queue_bank
   import oq_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                   ACLK,
   input  logic                   ARESETN,
   input  oq_enq_t                enq,
   input  logic                   deq,
   input  logic [QUEUE_IDX_W-1:0] deq_queue,
   input  logic                   reset_drop_counts,
   output logic                   out_valid,
   output logic [PAYLOAD_W-1:0]   out_payload,
   output logic [31:0]            drop_count_0,
   output logic [31:0]            drop_count_1,
   output logic [31:0]            drop_count_2,
   output logic [31:0]            drop_count_3,
   output logic [31:0]            drop_count_4
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   logic [PAYLOAD_W-1:0]  mem [NUM_QUEUES][QUEUE_DEPTH];
   logic [PTR_W-1:0]      rd_ptr [NUM_QUEUES];
   logic [PTR_W-1:0]      wr_ptr [NUM_QUEUES];
   logic [CNT_W-1:0]      count [NUM_QUEUES];
   logic [31:0]           drop_cnt [NUM_QUEUES];

   logic [NUM_QUEUES-1:0] full;
   logic [NUM_QUEUES-1:0] push;
   logic [NUM_QUEUES-1:0] pop;
   logic [NUM_QUEUES-1:0] count_drop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // per queue decisions
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // full uses occupancy before this cycle's dequeue
   // deq_queue beyond the last queue matches no q, so nothing is read
   always_comb begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
         full[q]       = (count[q] == CNT_W'(QUEUE_DEPTH));
         push[q]       = enq.valid && !enq.drop && !full[q] &&
                         (enq.queue == QUEUE_IDX_W'(q));
         count_drop[q] = enq.valid && (enq.drop || full[q]) &&
                         (enq.queue == QUEUE_IDX_W'(q));
         pop[q]        = deq && (deq_queue == QUEUE_IDX_W'(q)) && (count[q] != '0);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers, occupancy, dequeue result
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         out_valid <= 1'b0;
         for (int q = 0; q < NUM_QUEUES; q++) begin
            rd_ptr[q] <= '0;
            wr_ptr[q] <= '0;
            count[q]  <= '0;
         end
      end
      else begin
         out_valid <= |pop;
         for (int q = 0; q < NUM_QUEUES; q++) begin
            if (push[q]) begin
               wr_ptr[q] <= ptr_inc(wr_ptr[q]);
            end
            if (pop[q]) begin
               rd_ptr[q] <= ptr_inc(rd_ptr[q]);
            end
            count[q] <= count[q] + CNT_W'(push[q]) - CNT_W'(pop[q]);
         end
      end
   end

   always_ff @(posedge ACLK) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (push[q]) begin
            mem[q][wr_ptr[q]] <= enq.payload;
         end
         if (pop[q]) begin
            out_payload <= mem[q][rd_ptr[q]];
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // drop counters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // held at zero while software keeps the clear bit set; saturating
   always_ff @(posedge ACLK) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (!ARESETN || reset_drop_counts) begin
            drop_cnt[q] <= '0;
         end
         else if (count_drop[q] && (drop_cnt[q] != '1)) begin
            drop_cnt[q] <= drop_cnt[q] + 32'd1;
         end
      end
   end

   assign drop_count_0 = drop_cnt[0];
   assign drop_count_1 = drop_cnt[1];
   assign drop_count_2 = drop_cnt[2];
   assign drop_count_3 = drop_cnt[3];
   assign drop_count_4 = drop_cnt[4];

endmodule

//--- hdl/oq_regs.sv
`timescale 1ns/1ps

module oq_regs
   import oq_pkg::*;
#(
   parameter int DATA_WIDTH = 32,
   parameter int ADDR_WIDTH = 32
) (
   output logic [31:0]             queues_num,
   output logic                    reset_drop_counts,
   input  logic [31:0]             drop_count_0,
   input  logic [31:0]             drop_count_1,
   input  logic [31:0]             drop_count_2,
   input  logic [31:0]             drop_count_3,
   input  logic [31:0]             drop_count_4,

   input  logic                    ACLK,
   input  logic                    ARESETN,

   input  logic [ADDR_WIDTH-1:0]   AWADDR,
   input  logic                    AWVALID,
   output logic                    AWREADY,

   input  logic [DATA_WIDTH-1:0]   WDATA,
   input  logic [DATA_WIDTH/8-1:0] WSTRB,
   input  logic                    WVALID,
   output logic                    WREADY,

   output logic [1:0]              BRESP,
   output logic                    BVALID,
   input  logic                    BREADY,

   input  logic [ADDR_WIDTH-1:0]   ARADDR,
   input  logic                    ARVALID,
   output logic                    ARREADY,

   output logic [DATA_WIDTH-1:0]   RDATA,
   output logic [1:0]              RRESP,
   output logic                    RVALID,
   input  logic                    RREADY
);

   localparam logic [1:0] WR_IDLE = 2'd0;
   localparam logic [1:0] WR_DATA = 2'd1;
   localparam logic [1:0] WR_RESP = 2'd2;

   logic [1:0]            wr_state;
   logic [7:0]            wr_addr;

   logic                  rd_busy;
   logic [DATA_WIDTH-1:0] rd_data_nxt;
   logic [1:0]            rd_resp_nxt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // write channel
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign AWREADY = (wr_state == WR_IDLE);
   assign WREADY  = (wr_state == WR_DATA);
   assign BVALID  = (wr_state == WR_RESP);

   // only the low address byte is decoded
   always_ff @(posedge ACLK) begin
      if ((wr_state == WR_IDLE) && AWVALID) begin
         wr_addr <= AWADDR[7:0];
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state          <= WR_IDLE;
         BRESP             <= AXI_RESP_OK;
         queues_num        <= '0;
         reset_drop_counts <= 1'b0;
      end
      else begin
         case (wr_state)
            WR_IDLE: begin
               if (AWVALID) begin
                  wr_state <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (WVALID) begin
                  // wstrb ignored, whole word written
                  case (wr_addr)
                     REG_QUEUES_NUM: begin
                        queues_num <= 32'(WDATA);
                        BRESP      <= AXI_RESP_OK;
                     end
                     REG_RESET_DROP_COUNTS: begin
                        reset_drop_counts <= WDATA[0];
                        BRESP             <= AXI_RESP_OK;
                     end
                     default: begin
                        BRESP <= AXI_RESP_SLVERR;
                     end
                  endcase
                  wr_state <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (BREADY) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: begin
               wr_state <= WR_IDLE;
            end
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read channel
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign ARREADY = !rd_busy;
   assign RVALID  = rd_busy;

   always_comb begin
      rd_data_nxt = '0;
      rd_resp_nxt = AXI_RESP_OK;
      case (ARADDR[7:0])
         REG_QUEUES_NUM:             rd_data_nxt = DATA_WIDTH'(queues_num);
         REG_RESET_DROP_COUNTS:      rd_data_nxt = DATA_WIDTH'(reset_drop_counts);
         REG_DROP_COUNT_BASE:        rd_data_nxt = DATA_WIDTH'(drop_count_0);
         REG_DROP_COUNT_BASE + 8'd1: rd_data_nxt = DATA_WIDTH'(drop_count_1);
         REG_DROP_COUNT_BASE + 8'd2: rd_data_nxt = DATA_WIDTH'(drop_count_2);
         REG_DROP_COUNT_BASE + 8'd3: rd_data_nxt = DATA_WIDTH'(drop_count_3);
         REG_DROP_COUNT_BASE + 8'd4: rd_data_nxt = DATA_WIDTH'(drop_count_4);
         default:                    rd_resp_nxt = AXI_RESP_SLVERR;
      endcase
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rd_busy <= 1'b0;
      end
      else if (!rd_busy && ARVALID) begin
         rd_busy <= 1'b1;
      end
      else if (rd_busy && RREADY) begin
         rd_busy <= 1'b0;
      end
   end

   // data captured at accept, so it holds still through an RREADY stall
   always_ff @(posedge ACLK) begin
      if (!rd_busy && ARVALID) begin
         RDATA <= rd_data_nxt;
         RRESP <= rd_resp_nxt;
      end
   end

endmodule

//--- hdl/output_queues.sv
`timescale 1ns/1ps

module output_queues
   import oq_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4,
   parameter int DATA_WIDTH  = 32,
   parameter int ADDR_WIDTH  = 32
) (
   input  logic                    ACLK,
   input  logic                    ARESETN,

   // packet input and dequeue
   input  logic                    pkt_valid,
   input  oq_pkt_t                 pkt,
   input  logic                    deq,
   input  logic [QUEUE_IDX_W-1:0]  deq_queue,
   output logic                    out_valid,
   output logic [PAYLOAD_W-1:0]    out_payload,

   // axi-lite slave
   input  logic [ADDR_WIDTH-1:0]   AWADDR,
   input  logic                    AWVALID,
   output logic                    AWREADY,
   input  logic [DATA_WIDTH-1:0]   WDATA,
   input  logic [DATA_WIDTH/8-1:0] WSTRB,
   input  logic                    WVALID,
   output logic                    WREADY,
   output logic [1:0]              BRESP,
   output logic                    BVALID,
   input  logic                    BREADY,
   input  logic [ADDR_WIDTH-1:0]   ARADDR,
   input  logic                    ARVALID,
   output logic                    ARREADY,
   output logic [DATA_WIDTH-1:0]   RDATA,
   output logic [1:0]              RRESP,
   output logic                    RVALID,
   input  logic                    RREADY
);

   oq_enq_t     enq;
   logic [31:0] queues_num;
   logic        reset_drop_counts;
   logic [31:0] drop_count_0;
   logic [31:0] drop_count_1;
   logic [31:0] drop_count_2;
   logic [31:0] drop_count_3;
   logic [31:0] drop_count_4;

   oq_port_decode u_decode (
      .ARESETN    (ARESETN),
      .ACLK       (ACLK),
      .pkt_valid  (pkt_valid),
      .pkt        (pkt),
      .queues_num (queues_num),
      .enq        (enq)
   );

   oq_queue_bank #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue_bank (
      .ACLK              (ACLK),
      .ARESETN           (ARESETN),
      .enq               (enq),
      .deq               (deq),
      .deq_queue         (deq_queue),
      .reset_drop_counts (reset_drop_counts),
      .out_valid         (out_valid),
      .out_payload       (out_payload),
      .drop_count_0      (drop_count_0),
      .drop_count_1      (drop_count_1),
      .drop_count_2      (drop_count_2),
      .drop_count_3      (drop_count_3),
      .drop_count_4      (drop_count_4)
   );

   oq_regs #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_regs (
      .queues_num        (queues_num),
      .reset_drop_counts (reset_drop_counts),
      .drop_count_0      (drop_count_0),
      .drop_count_1      (drop_count_1),
      .drop_count_2      (drop_count_2),
      .drop_count_3      (drop_count_3),
      .drop_count_4      (drop_count_4),
      .ACLK              (ACLK),
      .ARESETN           (ARESETN),
      .AWADDR            (AWADDR),
      .AWVALID           (AWVALID),
      .AWREADY           (AWREADY),
      .WDATA             (WDATA),
      .WSTRB             (WSTRB),
      .WVALID            (WVALID),
      .WREADY            (WREADY),
      .BRESP             (BRESP),
      .BVALID            (BVALID),
      .BREADY            (BREADY),
      .ARADDR            (ARADDR),
      .ARVALID           (ARVALID),
      .ARREADY           (ARREADY),
      .RDATA             (RDATA),
      .RRESP             (RRESP),
      .RVALID            (RVALID),
      .RREADY            (RREADY)
   );

endmodule

//--- tb.f
hdl/oq_pkg.sv
hdl/oq_port_decode.sv
hdl/oq_queue_bank.sv
hdl/oq_regs.sv
hdl/output_queues.sv
tb/oq_checker.sv
tb/oq_properties.sv
tb/tb_output_queues.sv

//--- tb/oq_checker.sv
`timescale 1ns/1ps

module oq_checker
   import oq_pkg::*;
(
   input  logic                 ACLK,
   input  logic                 ARESETN,
   input  logic [1:0]           BRESP,
   input  logic                 BVALID,
   input  logic                 BREADY,
   input  logic [31:0]          RDATA,
   input  logic [1:0]           RRESP,
   input  logic                 RVALID,
   input  logic                 RREADY,
   input  logic                 deq,
   input  logic                 out_valid,
   input  logic [PAYLOAD_W-1:0] out_payload,
   input  logic                 exp_stb,
   input  logic [1:0]           exp_resp,
   input  logic [31:0]          exp_data,
   input  logic                 exp_valid,
   input  logic [PAYLOAD_W-1:0] exp_payload,
   output int                   checks,
   output int                   mismatches,
   output int                   sequence_errors,
   output logic                 armed
);

   logic deq_seen;

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic consume(input string what);
      if (!armed) begin
         $display("%s at %0t arrived with no expected value loaded", what, $time);
         sequence_errors++;
      end
      armed = 1'b0;
   endtask

   // handshakes seen mid cycle complete at the next rising edge
   always @(negedge ACLK) begin
      if (!ARESETN) begin
         armed    = 1'b0;
         deq_seen = 1'b0;
      end
      else begin
         if (BVALID && BREADY) begin
            consume("write response");
            compare("BRESP", 32'(exp_resp), 32'(BRESP));
         end
         if (RVALID && RREADY) begin
            consume("read response");
            compare("RDATA", exp_data, RDATA);
            compare("RRESP", 32'(exp_resp), 32'(RRESP));
         end
         // result of the dequeue one cycle back
         if (deq_seen) begin
            consume("dequeue result");
            compare("out_valid", 32'(exp_valid), 32'(out_valid));
            if (exp_valid) begin
               compare("out_payload", 32'(exp_payload), 32'(out_payload));
            end
         end
         deq_seen = deq;
         if (exp_stb) begin
            if (armed) begin
               $display("new expected value at %0t before the previous one was checked",
                        $time);
               sequence_errors++;
            end
            armed = 1'b1;
         end
      end
   end

endmodule

//--- tb/oq_properties.sv
`timescale 1ns/1ps

module oq_properties (
   input logic ACLK,
   input logic ARESETN,
   input logic AWVALID,
   input logic AWREADY,
   input logic WREADY,
   input logic BVALID,
   input logic BREADY,
   input logic RVALID,
   input logic RREADY,
   input logic out_valid
);

   int failures = 0;

   a_bvalid_hold: assert property (
      @(posedge ACLK) disable iff (!ARESETN) (BVALID && !BREADY) |=> BVALID
   ) else begin
      $error("BVALID dropped before BREADY was seen");
      failures++;
   end

   a_rvalid_hold: assert property (
      @(posedge ACLK) disable iff (!ARESETN) (RVALID && !RREADY) |=> RVALID
   ) else begin
      $error("RVALID dropped before RREADY was seen");
      failures++;
   end

   // accepted address moves the write fsm on to the data phase
   a_aw_to_w: assert property (
      @(posedge ACLK) disable iff (!ARESETN) (AWVALID && AWREADY) |=> (WREADY && !AWREADY)
   ) else begin
      $error("write data phase did not follow an accepted address");
      failures++;
   end

   a_out_valid_pulse: assert property (
      @(posedge ACLK) disable iff (!ARESETN) out_valid |=> !out_valid
   ) else begin
      $error("out_valid held for more than one cycle");
      failures++;
   end

endmodule

// register block has no dequeue output
bind oq_regs oq_properties u_regs_props (
   .ACLK      (ACLK),
   .ARESETN   (ARESETN),
   .AWVALID   (AWVALID),
   .AWREADY   (AWREADY),
   .WREADY    (WREADY),
   .BVALID    (BVALID),
   .BREADY    (BREADY),
   .RVALID    (RVALID),
   .RREADY    (RREADY),
   .out_valid (1'b0)
);

// queue bank with the bus inputs tied idle
bind oq_queue_bank oq_properties u_bank_props (
   .ACLK      (ACLK),
   .ARESETN   (ARESETN),
   .AWVALID   (1'b0),
   .AWREADY   (1'b0),
   .WREADY    (1'b0),
   .BVALID    (1'b0),
   .BREADY    (1'b1),
   .RVALID    (1'b0),
   .RREADY    (1'b1),
   .out_valid (out_valid)
);

//--- tb/oq_stim.txt
# op a b c, values in hex
# W addr data resp | R addr data resp | P queue payload | D queue valid payload | I cycles
# queues_num is 0 after reset, queue 2 packets are dropped and counted
P 2 a001
P 2 a002
P 2 a003
I 2
R 12 3 0
D 2 0 0
# register map, 0x00 queues_num, 0x01 reset_drop_counts, 0x10-0x14 drop counts
W 0 5 0
R 0 5 0
W 1 1 0
R 1 1 0
R 12 0 0
W 1 0 0
R 1 0 0
W 10 7 2
R 10 0 0
R 20 0 2
# fifo order on queue 1
P 1 1111
P 1 2222
P 1 3333
P 1 4444
I 2
D 1 1 1111
D 1 1 2222
D 1 1 3333
D 1 1 4444
D 1 0 0
# overflow on queue 4, depth 4
P 4 4001
P 4 4002
P 4 4003
P 4 4004
P 4 4005
P 4 4006
I 2
R 14 2 0
D 4 1 4001
D 4 1 4002
D 4 1 4003
D 4 1 4004
D 4 0 0
# three queues enabled, queue 6 does not exist
W 0 3 0
P 3 3abc
P 6 6def
I 2
R 13 1 0
R 14 2 0
R 10 0 0
R 11 0 0
R 12 0 0
W 1 1 0
W 1 0 0
R 10 0 0
R 11 0 0
R 12 0 0
R 13 0 0
R 14 0 0

//--- tb/tb_output_queues.sv
`timescale 1ns/1ps

module tb_output_queues
   import oq_pkg::*;
();

   localparam int    CLK_PERIOD      = 100;
   localparam string STIM_FILE       = "tb/oq_stim.txt";
   localparam int    CYCLES_PER_LINE = 10;
   localparam int    TIMEOUT_MARGIN  = 50;

   // one stimulus command as read from the file
   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
   } stim_t;

   logic                   ACLK = 1'b0;
   logic                   ARESETN;
   logic                   pkt_valid;
   oq_pkt_t                pkt;
   logic                   deq;
   logic [QUEUE_IDX_W-1:0] deq_queue;
   logic                   out_valid;
   logic [PAYLOAD_W-1:0]   out_payload;
   logic [31:0]            AWADDR;
   logic                   AWVALID;
   logic                   AWREADY;
   logic [31:0]            WDATA;
   logic [3:0]             WSTRB;
   logic                   WVALID;
   logic                   WREADY;
   logic [1:0]             BRESP;
   logic                   BVALID;
   logic                   BREADY;
   logic [31:0]            ARADDR;
   logic                   ARVALID;
   logic                   ARREADY;
   logic [31:0]            RDATA;
   logic [1:0]             RRESP;
   logic                   RVALID;
   logic                   RREADY;

   // expectations handed to the checker
   logic                   exp_stb;
   logic [1:0]             exp_resp;
   logic [31:0]            exp_data;
   logic                   exp_valid;
   logic [PAYLOAD_W-1:0]   exp_payload;

   int                     checks;
   int                     mismatches;
   int                     sequence_errors;
   logic                   armed;
   int                     stim_errors;
   int                     assert_fails;
   int                     total_errors;
   int                     cycle_count;
   int                     cycle_limit;
   stim_t                  stim_q[$];

   always #(CLK_PERIOD / 2) ACLK = ~ACLK;

   // stim file expectations assume a queue depth of 4
   output_queues #(
      .QUEUE_DEPTH (4),
      .DATA_WIDTH  (32),
      .ADDR_WIDTH  (32)
   ) u_output_queues (
      .ACLK        (ACLK),
      .ARESETN     (ARESETN),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt),
      .deq         (deq),
      .deq_queue   (deq_queue),
      .out_valid   (out_valid),
      .out_payload (out_payload),
      .AWADDR      (AWADDR),
      .AWVALID     (AWVALID),
      .AWREADY     (AWREADY),
      .WDATA       (WDATA),
      .WSTRB       (WSTRB),
      .WVALID      (WVALID),
      .WREADY      (WREADY),
      .BRESP       (BRESP),
      .BVALID      (BVALID),
      .BREADY      (BREADY),
      .ARADDR      (ARADDR),
      .ARVALID     (ARVALID),
      .ARREADY     (ARREADY),
      .RDATA       (RDATA),
      .RRESP       (RRESP),
      .RVALID      (RVALID),
      .RREADY      (RREADY)
   );

   oq_checker u_checker (
      .ACLK            (ACLK),
      .ARESETN         (ARESETN),
      .BRESP           (BRESP),
      .BVALID          (BVALID),
      .BREADY          (BREADY),
      .RDATA           (RDATA),
      .RRESP           (RRESP),
      .RVALID          (RVALID),
      .RREADY          (RREADY),
      .deq             (deq),
      .out_valid       (out_valid),
      .out_payload     (out_payload),
      .exp_stb         (exp_stb),
      .exp_resp        (exp_resp),
      .exp_data        (exp_data),
      .exp_valid       (exp_valid),
      .exp_payload     (exp_payload),
      .checks          (checks),
      .mismatches      (mismatches),
      .sequence_errors (sequence_errors),
      .armed           (armed)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stim file
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic load_stim();
      int          fd;
      int          ch;
      int          n;
      int          want;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open stimulus file %s", STIM_FILE);
         stim_errors++;
         return;
      end
      ch = $fgetc(fd);
      while (ch != -1) begin
         if (ch == "#") begin
            while (ch != -1 && ch != "\n") begin
               ch = $fgetc(fd);
            end
         end
         else if (ch == "W" || ch == "R" || ch == "P" || ch == "D" || ch == "I") begin
            a = '0;
            b = '0;
            c = '0;
            case (ch)
               "I": begin
                  want = 1;
                  n    = $fscanf(fd, "%h", a);
               end
               "P": begin
                  want = 2;
                  n    = $fscanf(fd, "%h %h", a, b);
               end
               default: begin
                  want = 3;
                  n    = $fscanf(fd, "%h %h %h", a, b, c);
               end
            endcase
            if (n != want) begin
               $display("malformed stimulus command %c after %0d commands", ch, stim_q.size());
               stim_errors++;
            end
            stim_q.push_back('{op: ch[7:0], a: a, b: b, c: c});
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // expectation goes out one cycle ahead of the transaction
   task automatic load_expect(input logic [1:0] resp, input logic [31:0] data,
                              input logic valid, input logic [PAYLOAD_W-1:0] payload);
      @(posedge ACLK);
      exp_resp    <= resp;
      exp_data    <= data;
      exp_valid   <= valid;
      exp_payload <= payload;
      exp_stb     <= 1'b1;
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge ACLK);
      exp_stb <= 1'b0;
      AWADDR  <= addr;
      AWVALID <= 1'b1;
      do @(negedge ACLK); while (!AWREADY);
      @(posedge ACLK);
      AWVALID <= 1'b0;
      WDATA   <= data;
      WVALID  <= 1'b1;
      do @(negedge ACLK); while (!WREADY);
      @(posedge ACLK);
      WVALID <= 1'b0;
      do @(negedge ACLK); while (!BVALID);
      // response stalled for one cycle before it is taken
      @(posedge ACLK);
      BREADY <= 1'b1;
      @(posedge ACLK);
      BREADY <= 1'b0;
   endtask

   task automatic reg_read(input logic [31:0] addr);
      @(posedge ACLK);
      exp_stb <= 1'b0;
      ARADDR  <= addr;
      ARVALID <= 1'b1;
      do @(negedge ACLK); while (!ARREADY);
      @(posedge ACLK);
      ARVALID <= 1'b0;
      do @(negedge ACLK); while (!RVALID);
      // response stalled for one cycle before it is taken
      @(posedge ACLK);
      RREADY <= 1'b1;
      @(posedge ACLK);
      RREADY <= 1'b0;
   endtask

   task automatic send_packet(input logic [QUEUE_IDX_W-1:0] dst,
                              input logic [PAYLOAD_W-1:0] payload);
      @(posedge ACLK);
      pkt_valid <= 1'b1;
      pkt       <= '{dst_queue: dst, payload: payload};
      @(posedge ACLK);
      pkt_valid <= 1'b0;
   endtask

   task automatic dequeue(input logic [QUEUE_IDX_W-1:0] queue);
      @(posedge ACLK);
      exp_stb   <= 1'b0;
      deq       <= 1'b1;
      deq_queue <= queue;
      @(posedge ACLK);
      deq <= 1'b0;
   endtask

   task automatic run_command(input stim_t s);
      case (s.op)
         "W": begin
            load_expect(s.c[1:0], '0, 1'b0, '0);
            reg_write(s.a, s.b);
         end
         "R": begin
            load_expect(s.c[1:0], s.b, 1'b0, '0);
            reg_read(s.a);
         end
         "P": send_packet(s.a[QUEUE_IDX_W-1:0], s.b[PAYLOAD_W-1:0]);
         "D": begin
            load_expect(AXI_RESP_OK, '0, s.b[0], s.c[PAYLOAD_W-1:0]);
            dequeue(s.a[QUEUE_IDX_W-1:0]);
         end
         default: repeat (s.a) @(posedge ACLK);
      endcase
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(posedge ACLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      ARESETN     = 1'b0;
      pkt_valid   = 1'b0;
      pkt         = '0;
      deq         = 1'b0;
      deq_queue   = '0;
      AWADDR      = '0;
      AWVALID     = 1'b0;
      WDATA       = '0;
      WSTRB       = 4'hf;
      WVALID      = 1'b0;
      BREADY      = 1'b0;
      ARADDR      = '0;
      ARVALID     = 1'b0;
      RREADY      = 1'b0;
      exp_stb     = 1'b0;
      exp_resp    = '0;
      exp_data    = '0;
      exp_valid   = 1'b0;
      exp_payload = '0;
      stim_errors = 0;
      cycle_count = 0;
      load_stim();
      cycle_limit = stim_q.size() * CYCLES_PER_LINE + TIMEOUT_MARGIN;
      repeat (3) @(posedge ACLK);
      ARESETN <= 1'b1;
      foreach (stim_q[i]) begin
         run_command(stim_q[i]);
      end
      repeat (3) @(posedge ACLK);
      if (armed) begin
         $display("last expected value was loaded but never checked");
         stim_errors++;
      end
      assert_fails = u_output_queues.u_regs.u_regs_props.failures +
                     u_output_queues.u_queue_bank.u_bank_props.failures;
      total_errors = mismatches + sequence_errors + stim_errors + assert_fails;
      $display("checks %0d, value errors %0d, sequence errors %0d, %s %0d, %s %0d",
               checks, mismatches, sequence_errors, "stimulus errors", stim_errors,
               "assertion failures", assert_fails);
      if (total_errors == 0) begin
         $display("TEST OK");
      end
      else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
